//--- rtl/mpmc_app_en_gen.sv
`timescale 1ns/10ps

module mpmc_app_en_gen (
	input  logic                          clk,
	input  logic                          rst,
	input  mpmc_pkg::mpmc_state_t         state,
	input  logic                          rdy,
	input  logic                          wdf_rdy,
	input  logic [mpmc_pkg::BURST_W-1:0]  burst_cnt,
	input  logic [mpmc_pkg::BURST_W-1:0]  burst_len,
	output logic                          en
);

	// The interface latches command and address only while app_rdy is high
	// A cycle without ready is simply offered again on the next cycle
	// Each issue state is left on the cycle its final command is taken
	always_comb begin
		en = ((state == mpmc_pkg::WRITE_DATA1) && rdy && wdf_rdy) ||
			((state == mpmc_pkg::READ_DATA0) && rdy) ||
			((state == mpmc_pkg::READ_DATA2) && rdy && (burst_cnt <= burst_len));
	end

endmodule

//--- rtl/mpmc_config.svh
`ifndef MPMC_CONFIG_SVH
`define MPMC_CONFIG_SVH

// ============================================================
// Controller sizing
// ============================================================

// Byte address width seen on the application interface
`define MPMC_ADDR_W 28

// Width of one data beat on the application interface
`define MPMC_DATA_W 128

// Byte distance between two consecutive beats of a read burst
`define MPMC_BEAT_STRIDE 16

// Largest value of the burst length field, which holds beats minus one
`define MPMC_MAX_BURST 255

`endif

//--- rtl/mpmc_data_path.sv
`timescale 1ns/10ps
`include "mpmc_config.svh"

module mpmc_data_path (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          req_valid,
	input  mpmc_pkg::mpmc_req_t           req,
	input  mpmc_pkg::mpmc_state_t         state,
	input  logic                          en,
	input  logic                          rdy,
	input  logic                          app_rd_data_valid,
	input  logic [`MPMC_DATA_W-1:0]       app_rd_data,
	output mpmc_pkg::mpmc_cmd_t           app_cmd,
	output logic [`MPMC_ADDR_W-1:0]       app_addr,
	output logic [`MPMC_DATA_W-1:0]       app_wdf_data,
	output logic [mpmc_pkg::BURST_W-1:0]  burst_cnt,
	output logic [mpmc_pkg::BURST_W-1:0]  burst_len,
	output logic                          beats_done,
	output logic                          rd_valid,
	output mpmc_pkg::mpmc_rbeat_t         rd_beat
);

	localparam logic [`MPMC_ADDR_W-1:0] STRIDE = `MPMC_BEAT_STRIDE;

	mpmc_pkg::mpmc_req_t          req_q;
	logic                         start;
	logic                         accept;
	logic [mpmc_pkg::BURST_W-1:0] rcnt;

	// New request taken in IDLE, and a command taken by the interface
	assign start  = req_valid && (state == mpmc_pkg::IDLE);
	assign accept = en && rdy;

	// ============================================================
	// Command side
	// ============================================================

	// Request is held for the whole transaction
	always_ff @(posedge clk) begin
		if (start) begin
			req_q <= req;
		end
	end

	assign app_cmd      = req_q.cmd;
	assign app_wdf_data = req_q.wdata;
	assign burst_len    = req_q.burst_len;

	// Beat address, one stride further after every accepted command
	always_ff @(posedge clk) begin
		if (start) begin
			app_addr <= req.addr;
		end else if (accept) begin
			app_addr <= app_addr + STRIDE;
		end
	end

	// Number of commands the interface has taken so far
	always_ff @(posedge clk) begin
		if (rst) begin
			burst_cnt <= '0;
		end else if (start) begin
			burst_cnt <= '0;
		end else if (accept) begin
			burst_cnt <= burst_cnt + 1'b1;
		end
	end

	// ============================================================
	// Return side
	// ============================================================

	// Beats come back in order, so a running count is the beat index
	// beats_done is raised in the same cycle as the last beat on rd_valid
	always_ff @(posedge clk) begin
		if (rst) begin
			rcnt       <= '0;
			beats_done <= 1'b0;
			rd_valid   <= 1'b0;
		end else begin
			rd_valid <= app_rd_data_valid;
			if (start) begin
				rcnt       <= '0;
				beats_done <= 1'b0;
			end else if (app_rd_data_valid) begin
				rcnt <= rcnt + 1'b1;
				if (rcnt == burst_len) begin
					beats_done <= 1'b1;
				end
			end
		end
	end

	// Tagged beat for the requester
	always_ff @(posedge clk) begin
		if (app_rd_data_valid) begin
			rd_beat.idx  <= rcnt;
			rd_beat.data <= app_rd_data;
		end
	end

endmodule

//--- rtl/mpmc_pkg.sv
`include "mpmc_config.svh"

package mpmc_pkg;

	// Width of the burst length field and of the beat counters
	localparam int BURST_W = $clog2(`MPMC_MAX_BURST + 1);

	// Sequencer states
	// WRITE_DATA1 holds the write until the interface takes it, READ_DATA0 issues beat 0
	// and READ_DATA2 issues the rest of the burst
	typedef enum logic [2:0] {
		IDLE,
		WRITE_DATA0,
		WRITE_DATA1,
		READ_DATA0,
		READ_DATA2,
		READ_WAIT,
		DONE
	} mpmc_state_t;

	// Command codes as the application interface expects them
	typedef enum logic [2:0] {
		CMD_WRITE = 3'd0,
		CMD_READ  = 3'd1
	} mpmc_cmd_t;

	// One request from the requester
	typedef struct packed {
		mpmc_cmd_t                cmd;
		logic [`MPMC_ADDR_W-1:0]  addr;
		logic [BURST_W-1:0]       burst_len;
		logic [`MPMC_DATA_W-1:0]  wdata;
	} mpmc_req_t;

	// One returned read beat, tagged with its position in the burst
	typedef struct packed {
		logic [BURST_W-1:0]       idx;
		logic [`MPMC_DATA_W-1:0]  data;
	} mpmc_rbeat_t;

endpackage

//--- rtl/mpmc_state_machine.sv
`timescale 1ns/10ps

module mpmc_state_machine (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          req_valid,
	input  mpmc_pkg::mpmc_cmd_t           cmd,
	input  logic                          rdy,
	input  logic                          wdf_rdy,
	input  logic [mpmc_pkg::BURST_W-1:0]  burst_cnt,
	input  logic [mpmc_pkg::BURST_W-1:0]  burst_len,
	input  logic                          beats_done,
	output mpmc_pkg::mpmc_state_t         state
);

	mpmc_pkg::mpmc_state_t state_nxt;
	logic                  last_cmd;

	// The command being offered is the final one of the burst
	// In READ_DATA0 the counter is still zero, so this also covers single beat reads
	assign last_cmd = (burst_cnt == burst_len);

	// ============================================================
	// Next state
	// ============================================================
	always_comb begin
		state_nxt = state;
		case (state)
		mpmc_pkg::IDLE: begin
			// A request is only taken here, busy keeps the requester quiet elsewhere
			if (req_valid) begin
				if (cmd == mpmc_pkg::CMD_WRITE) begin
					state_nxt = mpmc_pkg::WRITE_DATA0;
				end else begin
					state_nxt = mpmc_pkg::READ_DATA0;
				end
			end
		end
		mpmc_pkg::WRITE_DATA0: begin
			// One cycle for the registered request to reach the interface
			state_nxt = mpmc_pkg::WRITE_DATA1;
		end
		mpmc_pkg::WRITE_DATA1: begin
			// Command and data have to be taken in the same cycle
			if (rdy && wdf_rdy) begin
				state_nxt = mpmc_pkg::DONE;
			end
		end
		mpmc_pkg::READ_DATA0: begin
			// Beat 0 goes out on the first ready cycle
			if (rdy) begin
				if (last_cmd) begin
					state_nxt = mpmc_pkg::READ_WAIT;
				end else begin
					state_nxt = mpmc_pkg::READ_DATA2;
				end
			end
		end
		mpmc_pkg::READ_DATA2: begin
			// Stay until the interface has taken the last command of the burst
			if (rdy && last_cmd) begin
				state_nxt = mpmc_pkg::READ_WAIT;
			end
		end
		mpmc_pkg::READ_WAIT: begin
			// Several reads may still be in flight after the last command
			if (beats_done) begin
				state_nxt = mpmc_pkg::DONE;
			end
		end
		mpmc_pkg::DONE: begin
			state_nxt = mpmc_pkg::IDLE;
		end
		default: begin
			state_nxt = mpmc_pkg::IDLE;
		end
		endcase
	end

	// ============================================================
	// State register
	// ============================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mpmc_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

endmodule

//--- rtl/mpmc_top.sv
`timescale 1ns/10ps
`include "mpmc_config.svh"

module mpmc_top (
	input  logic                     clk,
	input  logic                     rst,
	// Requester side
	input  logic                     req_valid,
	input  mpmc_pkg::mpmc_req_t      req,
	output logic                     busy,
	output logic                     done,
	output logic                     rd_valid,
	output mpmc_pkg::mpmc_rbeat_t    rd_beat,
	// Application interface
	output logic                     app_en,
	output mpmc_pkg::mpmc_cmd_t      app_cmd,
	output logic [`MPMC_ADDR_W-1:0]  app_addr,
	input  logic                     app_rdy,
	output logic [`MPMC_DATA_W-1:0]  app_wdf_data,
	output logic                     app_wdf_wren,
	output logic                     app_wdf_end,
	input  logic                     app_wdf_rdy,
	input  logic [`MPMC_DATA_W-1:0]  app_rd_data,
	input  logic                     app_rd_data_valid
);

	mpmc_pkg::mpmc_state_t        state;
	logic [mpmc_pkg::BURST_W-1:0] burst_cnt;
	logic [mpmc_pkg::BURST_W-1:0] burst_len;
	logic                         beats_done;

	// ============================================================
	// Sequencer
	// ============================================================
	mpmc_state_machine u_state_machine (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.cmd        (req.cmd),
		.rdy        (app_rdy),
		.wdf_rdy    (app_wdf_rdy),
		.burst_cnt  (burst_cnt),
		.burst_len  (burst_len),
		.beats_done (beats_done),
		.state      (state)
	);

	// Command enable
	mpmc_app_en_gen u_app_en_gen (
		.clk       (clk),
		.rst       (rst),
		.state     (state),
		.rdy       (app_rdy),
		.wdf_rdy   (app_wdf_rdy),
		.burst_cnt (burst_cnt),
		.burst_len (burst_len),
		.en        (app_en)
	);

	// Request, address and beat handling
	mpmc_data_path u_data_path (
		.clk               (clk),
		.rst               (rst),
		.req_valid         (req_valid),
		.req               (req),
		.state             (state),
		.en                (app_en),
		.rdy               (app_rdy),
		.app_rd_data_valid (app_rd_data_valid),
		.app_rd_data       (app_rd_data),
		.app_cmd           (app_cmd),
		.app_addr          (app_addr),
		.app_wdf_data      (app_wdf_data),
		.burst_cnt         (burst_cnt),
		.burst_len         (burst_len),
		.beats_done        (beats_done),
		.rd_valid          (rd_valid),
		.rd_beat           (rd_beat)
	);

	// Single beat writes, so the data strobe and its end marker go with the command
	assign app_wdf_wren = app_en && (state == mpmc_pkg::WRITE_DATA1);
	assign app_wdf_end  = app_en && (state == mpmc_pkg::WRITE_DATA1);

	// Busy covers everything from the cycle after acceptance up to the done cycle
	assign busy = (state != mpmc_pkg::IDLE);
	assign done = (state == mpmc_pkg::DONE);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module mpmc_tb \
	--Mdir obj_dir -o mpmc_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mpmc_sim +verilator+error+limit+100 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulator exited with status $run_status"
fi

if grep -q "^RESULT: PASS$" sim.log; then
	exit 0
fi
exit 1

//--- sim/mpmc_app_model.sv
`timescale 1ns/10ps
`include "mpmc_config.svh"

module mpmc_app_model (
	input  logic                     clk,
	input  logic                     rst,
	// Back-pressure controls from the testbench
	input  logic                     random_bp,
	input  logic                     withhold,
	// Application interface as seen from the memory side
	input  logic                     app_en,
	input  mpmc_pkg::mpmc_cmd_t      app_cmd,
	input  logic [`MPMC_ADDR_W-1:0]  app_addr,
	output logic                     app_rdy,
	input  logic [`MPMC_DATA_W-1:0]  app_wdf_data,
	input  logic                     app_wdf_wren,
	input  logic                     app_wdf_end,
	output logic                     app_wdf_rdy,
	output logic [`MPMC_DATA_W-1:0]  app_rd_data,
	output logic                     app_rd_data_valid
);

	localparam int RD_LAT = 6;

	integer                  seed = 32'h2686882a;
	logic [`MPMC_DATA_W-1:0] mem [logic [`MPMC_ADDR_W-1:0]];
	logic [RD_LAT-1:0]       vpipe;
	logic [`MPMC_DATA_W-1:0] dpipe [RD_LAT];
	logic                    rd_take;
	logic                    wr_take;

	// Locations never written return a word built from the whole address
	function automatic logic [`MPMC_DATA_W-1:0] fill_word(input logic [`MPMC_ADDR_W-1:0] a);
		return {4{{4'h0, a} ^ 32'h6d3a19c5}};
	endfunction

	assign rd_take = app_en && app_rdy && (app_cmd == mpmc_pkg::CMD_READ);
	assign wr_take = app_en && app_rdy && app_wdf_rdy && app_wdf_wren && app_wdf_end &&
		(app_cmd == mpmc_pkg::CMD_WRITE);

	// ============================================================
	// Ready generation, memory and read return pipe
	// ============================================================
	always @(posedge clk) begin
		if (rst) begin
			app_rdy     <= 1'b0;
			app_wdf_rdy <= 1'b0;
			vpipe       <= '0;
		end else begin
			// Ready changes right after the edge, so it is steady at the next one
			if (withhold) begin
				app_rdy     <= 1'b0;
				app_wdf_rdy <= 1'b0;
			end else if (random_bp) begin
				app_rdy     <= ($random(seed) & 3) != 0;
				app_wdf_rdy <= ($random(seed) & 3) != 0;
			end else begin
				app_rdy     <= 1'b1;
				app_wdf_rdy <= 1'b1;
			end
			if (wr_take) begin
				mem[app_addr] = app_wdf_data;
			end
			// Reads stay in order and several can be in flight
			vpipe    <= {vpipe[RD_LAT-2:0], rd_take};
			dpipe[0] <= mem.exists(app_addr) ? mem[app_addr] : fill_word(app_addr);
			for (int i = 1; i < RD_LAT; i++) begin
				dpipe[i] <= dpipe[i-1];
			end
		end
	end

	assign app_rd_data_valid = vpipe[RD_LAT-1];
	assign app_rd_data       = dpipe[RD_LAT-1];

endmodule

//--- sim/mpmc_checker.sv
`timescale 1ns/10ps

module mpmc_checker (
	input  logic                   clk,
	input  logic                   rst,
	input  mpmc_pkg::mpmc_state_t  state,
	input  logic                   app_en,
	input  logic                   app_wdf_wren,
	input  logic                   app_wdf_end,
	input  logic                   done
);

	// Count of failed assertions, watched by the testbench
	int fail_cnt = 0;

	// ============================================================
	// Protocol properties
	// ============================================================

	// No command may be offered while the sequencer waits for a request
	a_no_en_in_idle: assert property (@(posedge clk) disable iff (rst)
		(state == mpmc_pkg::IDLE) |-> !app_en)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("app_en is high while the sequencer is idle");
	end

	// Single beat writes put the data strobes on the command cycle only
	a_wdf_with_en: assert property (@(posedge clk) disable iff (rst)
		(app_wdf_wren || app_wdf_end) |-> (app_en && app_wdf_wren && app_wdf_end))
	else begin
		fail_cnt = fail_cnt + 1;
		$error("Write data strobes are high without app_en or apart from each other");
	end

	// Completion lasts exactly one cycle
	a_done_pulse: assert property (@(posedge clk) disable iff (rst)
		done |=> !done)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("done stayed high for more than one cycle");
	end

endmodule

bind mpmc_top mpmc_checker u_checker (
	.clk          (clk),
	.rst          (rst),
	.state        (state),
	.app_en       (app_en),
	.app_wdf_wren (app_wdf_wren),
	.app_wdf_end  (app_wdf_end),
	.done         (done)
);

//--- sim/mpmc_patterns.hex
// Columns: mode cmd addr burst_len wdata (burst_len holds beats minus one)
// Mode 0 is always ready, 1 random back-pressure, 2 ready withheld at first, f ends the list
0 0 0000100 00 0123456789abcdef0011223344556677
2 0 0000110 00 fedcba98765432108899aabbccddeeff
0 1 0000100 00 00000000000000000000000000000000
1 1 0000100 03 00000000000000000000000000000000
1 0 0000130 00 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0
1 1 0000120 07 00000000000000000000000000000000
1 1 1000000 0f 00000000000000000000000000000000
0 1 0000110 00 00000000000000000000000000000000
1 0 0000140 00 13572468ace0bdf19753864202468ace
1 1 0000100 1f 00000000000000000000000000000000
f 0 0000000 00 00000000000000000000000000000000

//--- sim/mpmc_tb.sv
`timescale 1ns/10ps
`include "mpmc_config.svh"

module mpmc_tb;

	localparam int MAX_PAT    = 32;
	localparam int RD_LAT     = 6;
	localparam int RST_CYCLES = 16;
	localparam logic [`MPMC_ADDR_W-1:0] STRIDE = `MPMC_BEAT_STRIDE;

	logic                    clk = 1'b0;
	logic                    rst;
	logic                    req_valid;
	mpmc_pkg::mpmc_req_t     req;
	logic                    busy;
	logic                    done;
	logic                    rd_valid;
	mpmc_pkg::mpmc_rbeat_t   rd_beat;
	logic                    app_en;
	mpmc_pkg::mpmc_cmd_t     app_cmd;
	logic [`MPMC_ADDR_W-1:0] app_addr;
	logic                    app_rdy;
	logic [`MPMC_DATA_W-1:0] app_wdf_data;
	logic                    app_wdf_wren;
	logic                    app_wdf_end;
	logic                    app_wdf_rdy;
	logic [`MPMC_DATA_W-1:0] app_rd_data;
	logic                    app_rd_data_valid;
	logic                    random_bp;
	logic                    withhold;

	// Five words per pattern: mode, cmd, addr, burst_len and wdata
	logic [`MPMC_DATA_W-1:0] pat_words [MAX_PAT*5];
	logic [`MPMC_DATA_W-1:0] image [logic [`MPMC_ADDR_W-1:0]];
	mpmc_pkg::mpmc_cmd_t     exp_cmd [$];
	logic [`MPMC_ADDR_W-1:0] exp_addr [$];
	logic [`MPMC_DATA_W-1:0] exp_wdata [$];
	mpmc_pkg::mpmc_rbeat_t   exp_beats [$];
	int                      npat;
	int                      limit;
	int                      cycles;
	int                      accepted;
	int                      done_cnt;

	always #4 clk = ~clk;

	mpmc_top dut (.*);

	mpmc_app_model u_app_model (.*);

	// ============================================================
	// Failure reporting and compare tasks
	// ============================================================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_cmd(input mpmc_pkg::mpmc_cmd_t got, input mpmc_pkg::mpmc_cmd_t exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] app_cmd got %h expected %h", got, exp));
		end
	endtask

	task automatic check_addr(input logic [`MPMC_ADDR_W-1:0] got,
		input logic [`MPMC_ADDR_W-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] app_addr got %h expected %h", got, exp));
		end
	endtask

	task automatic check_data(input string name, input logic [`MPMC_DATA_W-1:0] got,
		input logic [`MPMC_DATA_W-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_beat(input mpmc_pkg::mpmc_rbeat_t got,
		input mpmc_pkg::mpmc_rbeat_t exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] rd_beat got idx %h data %h expected idx %h data %h",
				got.idx, got.data, exp.idx, exp.data));
		end
	endtask

	// Expected content of a location, from writes seen so far or the fill rule
	function automatic logic [`MPMC_DATA_W-1:0] image_word(input logic [`MPMC_ADDR_W-1:0] a);
		if (image.exists(a)) begin
			return image[a];
		end
		return {4{{4'h0, a} ^ 32'h6d3a19c5}};
	endfunction

	// ============================================================
	// Monitor and timeout
	// ============================================================

	// Values are taken at the rising edge, before any register updates
	always @(posedge clk) begin
		if (!rst) begin
			if (app_en && app_rdy) begin
				if (exp_cmd.size() == 0) begin
					abort_run("A command was accepted although none was outstanding");
				end else begin
					check_cmd(app_cmd, exp_cmd.pop_front());
					check_addr(app_addr, exp_addr.pop_front());
					if (app_cmd == mpmc_pkg::CMD_WRITE) begin
						check_flag("app_wdf_wren", app_wdf_wren, 1'b1);
						check_flag("app_wdf_end", app_wdf_end, 1'b1);
						check_data("app_wdf_data", app_wdf_data, exp_wdata.pop_front());
					end
				end
				accepted = accepted + 1;
			end
			if (rd_valid) begin
				if (exp_beats.size() == 0) begin
					abort_run("A read beat arrived although none was outstanding");
				end else begin
					check_beat(rd_beat, exp_beats.pop_front());
				end
			end
			if (done) begin
				done_cnt = done_cnt + 1;
				if (exp_cmd.size() != 0 || exp_beats.size() != 0) begin
					abort_run("done was raised before every command and beat had finished");
				end
			end
			if (dut.u_checker.fail_cnt != 0) begin
				abort_run("A protocol assertion on the DUT failed");
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			abort_run($sformatf("Timeout after %0d cycles before all patterns ended", cycles));
		end
	end

	// ============================================================
	// Stimulus
	// ============================================================
	task automatic run_pattern(input int idx);
		mpmc_pkg::mpmc_req_t     r;
		mpmc_pkg::mpmc_rbeat_t   b;
		logic [3:0]              mode;
		logic [`MPMC_ADDR_W-1:0] a;
		int                      base_acc;
		int                      base_done;
		int                      n_cmd;
		mode        = pat_words[5*idx][3:0];
		r.cmd       = mpmc_pkg::mpmc_cmd_t'(pat_words[5*idx+1][2:0]);
		r.addr      = pat_words[5*idx+2][`MPMC_ADDR_W-1:0];
		r.burst_len = pat_words[5*idx+3][mpmc_pkg::BURST_W-1:0];
		r.wdata     = pat_words[5*idx+4];
		// A new request only goes out once the previous one has left busy
		while (busy) begin
			@(negedge clk);
		end
		random_bp = (mode == 4'h1);
		withhold  = (mode == 4'h2);
		a = r.addr;
		if (r.cmd == mpmc_pkg::CMD_WRITE) begin
			n_cmd = 1;
			exp_cmd.push_back(mpmc_pkg::CMD_WRITE);
			exp_addr.push_back(a);
			exp_wdata.push_back(r.wdata);
			image[a] = r.wdata;
		end else begin
			n_cmd = int'(r.burst_len) + 1;
			for (int i = 0; i < n_cmd; i++) begin
				exp_cmd.push_back(mpmc_pkg::CMD_READ);
				exp_addr.push_back(a);
				b.idx  = i[mpmc_pkg::BURST_W-1:0];
				b.data = image_word(a);
				exp_beats.push_back(b);
				a = a + STRIDE;
			end
		end
		base_acc  = accepted;
		base_done = done_cnt;
		req       = r;
		req_valid = 1'b1;
		@(negedge clk);
		req_valid = 1'b0;
		check_flag("busy", busy, 1'b1);
		// Nothing may be taken while the interface holds off, then ready returns
		if (mode == 4'h2) begin
			repeat (5) @(negedge clk);
			if (accepted != base_acc) begin
				abort_run("A command was accepted while the interface withheld ready");
			end
			withhold = 1'b0;
		end
		while (done_cnt == base_done) begin
			@(negedge clk);
		end
		check_flag("done", done, 1'b0);
		check_flag("busy", busy, 1'b0);
		if (accepted - base_acc != n_cmd) begin
			abort_run($sformatf("Pattern %0d had %0d accepted commands instead of %0d",
				idx, accepted - base_acc, n_cmd));
		end
	endtask

	initial begin
		rst       = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		random_bp = 1'b0;
		withhold  = 1'b0;
		cycles    = 0;
		accepted  = 0;
		done_cnt  = 0;
		$readmemh("sim/mpmc_patterns.hex", pat_words);
		// Count patterns up to the end marker and size the run limit from them
		npat  = 0;
		limit = RST_CYCLES;
		while (npat < MAX_PAT && pat_words[5*npat][3:0] != 4'hf) begin
			limit = limit + (int'(pat_words[5*npat+3][mpmc_pkg::BURST_W-1:0]) + 1 + RD_LAT) * 20;
			npat = npat + 1;
		end
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_flag("app_en", app_en, 1'b0);
		check_flag("app_wdf_wren", app_wdf_wren, 1'b0);
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);
		check_flag("rd_valid", rd_valid, 1'b0);
		for (int p = 0; p < npat; p++) begin
			run_pattern(p);
		end
		repeat (4) @(negedge clk);
		if (npat > 0 && done_cnt == npat && exp_cmd.size() == 0 && exp_beats.size() == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			abort_run("The run ended with patterns missing or outstanding work left over");
		end
	end

endmodule

//--- vlog.f
+incdir+rtl
rtl/mpmc_pkg.sv
rtl/mpmc_state_machine.sv
rtl/mpmc_app_en_gen.sv
rtl/mpmc_data_path.sv
rtl/mpmc_top.sv
sim/mpmc_app_model.sv
sim/mpmc_checker.sv
sim/mpmc_tb.sv
